//--- src/timer_config.svh
/*
 * Build-time sizes of the timer subsystem.
 * Number of timer slots, APB address width and bus data width.
 */

`ifndef TIMER_CONFIG_SVH
`define TIMER_CONFIG_SVH

// Number of timer slots up to 16 for the 4-bit slot field
`define TIMER_COUNT 4

// APB address width seen by the slots
`define TIMER_ADDR_WIDTH 12

// Bus and register data width
`define TIMER_DATA_WIDTH 32

`endif

//--- src/timer_pkg.sv
/*
 * Shared types of the timer subsystem.
 * APB address union, register index enum, AHB response enum.
 */

package timer_pkg;

`include "timer_config.svh"

  // APB address read either raw or split into slot, word and byte lane
  typedef union packed {
    logic [`TIMER_ADDR_WIDTH-1:0] raw;
    struct packed {
      logic [3:0] slot;
      logic [5:0] word;
      logic [1:0] lane;
    } fields;
  } timer_addr_u;

  // Register index within one slot
  typedef enum logic [5:0] {
    REG_CTRL    = 6'd0,
    REG_VALUE   = 6'd1,
    REG_RELOAD  = 6'd2,
    REG_INTSTAT = 6'd3
  } timer_reg_e;

  // Single-bit AHB-Lite response
  typedef enum logic {
    HRESP_OKAY  = 1'b0,
    HRESP_ERROR = 1'b1
  } hresp_e;

endpackage

//--- src/ahb_apb_bridge.sv
/*
 * AHB-Lite slave to APB master bridge.
 * One APB setup/access pair per accepted transfer, registered read data
 * and a two-cycle ERROR response on pslverr.
 */

`timescale 1ns/1ps

`include "timer_config.svh"

module ahb_apb_bridge
  import timer_pkg::*;
(
  input  logic                         hclk,
  input  logic                         reset,
  // AHB-Lite slave side
  input  logic                         hsel,
  input  logic [31:0]                  haddr,
  input  logic [1:0]                   htrans,
  input  logic                         hwrite,
  input  logic [`TIMER_DATA_WIDTH-1:0] hwdata,
  input  logic                         hready_in,
  output logic [`TIMER_DATA_WIDTH-1:0] hrdata,
  output logic                         hreadyout,
  output hresp_e                       hresp,
  // APB master side
  output timer_addr_u                  paddr,
  output logic                         psel,
  output logic                         penable,
  output logic                         pwrite,
  output logic [`TIMER_DATA_WIDTH-1:0] pwdata,
  input  logic [`TIMER_DATA_WIDTH-1:0] prdata,
  input  logic                         pready,
  input  logic                         pslverr
);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_SETUP  = 2'd1;
  localparam logic [1:0] ST_ACCESS = 2'd2;
  localparam logic [1:0] ST_ERROR  = 2'd3;

  logic [1:0]                   state;
  logic [`TIMER_DATA_WIDTH-1:0] wdata_q;
  logic                         accept;
  logic                         apb_done;

  // --------------------------------------------------------------------------
  // Transfer acceptance
  // --------------------------------------------------------------------------

  // NONSEQ and SEQ both have htrans[1] set and IDLE and BUSY do not
  assign accept   = hsel && hready_in && htrans[1] && hreadyout;
  assign apb_done = (state == ST_ACCESS) && pready;

  always_ff @(posedge hclk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE, ST_ERROR: begin
          if (accept) begin
            state <= ST_SETUP;
          end else begin
            state <= ST_IDLE;
          end
        end
        ST_SETUP: begin
          state <= ST_ACCESS;
        end
        ST_ACCESS: begin
          if (pready) begin
            state <= pslverr ? ST_ERROR : ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Address phase capture
  always_ff @(posedge hclk) begin
    if (accept) begin
      paddr.raw <= haddr[`TIMER_ADDR_WIDTH-1:0];
      pwrite    <= hwrite;
    end
  end

  // Write data is valid from the first data phase cycle on
  always_ff @(posedge hclk) begin
    if (state == ST_SETUP) begin
      wdata_q <= hwdata;
    end
  end

  assign pwdata = (state == ST_SETUP) ? hwdata : wdata_q;

  // --------------------------------------------------------------------------
  // APB strobes and AHB response
  // --------------------------------------------------------------------------

  assign psel    = (state == ST_SETUP) || (state == ST_ACCESS);
  assign penable = (state == ST_ACCESS);

  // Read data lands together with the rising hreadyout
  always_ff @(posedge hclk) begin
    if (apb_done) begin
      hrdata <= pslverr ? '0 : prdata;
    end
  end

  assign hreadyout = (state == ST_IDLE) || (state == ST_ERROR);

  // First ERROR cycle is the access cycle itself with hreadyout still low
  assign hresp = ((state == ST_ERROR) || (apb_done && pslverr)) ? HRESP_ERROR : HRESP_OKAY;

endmodule

//--- src/apb_slot_decoder.sv
/*
 * APB slot decoder.
 * One-hot slot select from the address slot field, decode error for
 * slots beyond the timer array.
 */

`timescale 1ns/1ps

`include "timer_config.svh"

module apb_slot_decoder
  import timer_pkg::*;
(
  input  logic                    psel,
  input  timer_addr_u             paddr,
  output logic [`TIMER_COUNT-1:0] slot_sel,
  output logic                    decode_err
);

  logic in_range;

  // Slot field compared as an integer so a full 16-slot array still works
  assign in_range = int'(paddr.fields.slot) < `TIMER_COUNT;

  always_comb begin
    slot_sel = '0;
    for (int i = 0; i < `TIMER_COUNT; i++) begin
      if (psel && (int'(paddr.fields.slot) == i)) begin
        slot_sel[i] = 1'b1;
      end
    end
  end

  // Nothing answers outside the array, so the decoder flags it
  assign decode_err = psel && !in_range;

endmodule

//--- src/apb_timer.sv
/*
 * Single down-counting timer with APB register file.
 * Registers CTRL, VALUE, RELOAD and INTSTAT/INTCLEAR, level interrupt.
 */

`timescale 1ns/1ps

`include "timer_config.svh"

module apb_timer
  import timer_pkg::*;
(
  input  logic                         hclk,
  input  logic                         reset,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  timer_reg_e                   pword,
  input  logic [`TIMER_DATA_WIDTH-1:0] pwdata,
  output logic [`TIMER_DATA_WIDTH-1:0] prdata,
  output logic                         pready,
  output logic                         timerint
);

  logic                         ctrl_en;
  logic                         ctrl_int_en;
  logic [`TIMER_DATA_WIDTH-1:0] value;
  logic [`TIMER_DATA_WIDTH-1:0] reload;
  logic                         int_stat;
  logic                         wr_en;
  logic                         reload_hit;

  // No wait states
  assign pready = 1'b1;

  assign wr_en      = psel && penable && pwrite;
  assign reload_hit = ctrl_en && (value == '0);

  // --------------------------------------------------------------------------
  // Register writes and counter
  // --------------------------------------------------------------------------

  always_ff @(posedge hclk) begin
    if (reset) begin
      ctrl_en     <= 1'b0;
      ctrl_int_en <= 1'b0;
      reload      <= '0;
    end else if (wr_en) begin
      if (pword == REG_CTRL) begin
        ctrl_en     <= pwdata[0];
        ctrl_int_en <= pwdata[1];
      end
      if (pword == REG_RELOAD) begin
        reload <= pwdata;
      end
    end
  end

  // A bus write to VALUE wins over the count step
  always_ff @(posedge hclk) begin
    if (reset) begin
      value <= '0;
    end else if (wr_en && (pword == REG_VALUE)) begin
      value <= pwdata;
    end else if (reload_hit) begin
      value <= reload;
    end else if (ctrl_en) begin
      value <= value - 1'b1;
    end
  end

  // Set on reload beats a simultaneous clear
  always_ff @(posedge hclk) begin
    if (reset) begin
      int_stat <= 1'b0;
    end else if (reload_hit) begin
      int_stat <= 1'b1;
    end else if (wr_en && (pword == REG_INTSTAT) && pwdata[0]) begin
      int_stat <= 1'b0;
    end
  end

  assign timerint = int_stat && ctrl_int_en;

  // --------------------------------------------------------------------------
  // Read mux
  // --------------------------------------------------------------------------

  always_comb begin
    case (pword)
      REG_CTRL:    prdata = {{(`TIMER_DATA_WIDTH-2){1'b0}}, ctrl_int_en, ctrl_en};
      REG_VALUE:   prdata = value;
      REG_RELOAD:  prdata = reload;
      REG_INTSTAT: prdata = {{(`TIMER_DATA_WIDTH-1){1'b0}}, int_stat};
      // unused words read as zero
      default:     prdata = '0;
    endcase
  end

endmodule

//--- src/apb_return_mux.sv
/*
 * APB return path of the timer array.
 * AND-OR select of read data and ready, decode-error response,
 * OR of the timer interrupts.
 */

`timescale 1ns/1ps

`include "timer_config.svh"

module apb_return_mux (
  input  logic [`TIMER_COUNT-1:0]      slot_sel,
  input  logic                         decode_err,
  input  logic [`TIMER_DATA_WIDTH-1:0] slot_rdata [`TIMER_COUNT],
  input  logic [`TIMER_COUNT-1:0]      slot_ready,
  input  logic [`TIMER_COUNT-1:0]      slot_int,
  output logic [`TIMER_DATA_WIDTH-1:0] prdata,
  output logic                         pready,
  output logic                         pslverr,
  output logic                         timerint
);

  // slot_sel is one-hot or zero, so the OR never mixes two slots
  always_comb begin
    prdata = '0;
    for (int i = 0; i < `TIMER_COUNT; i++) begin
      prdata = prdata | (slot_rdata[i] & {`TIMER_DATA_WIDTH{slot_sel[i]}});
    end
  end

  // Decode error answers at once with zero data
  assign pready  = (|(slot_sel & slot_ready)) || decode_err;
  assign pslverr = decode_err;

  assign timerint = |slot_int;

endmodule

//--- src/timer_subsystem.sv
/*
 * Timer subsystem top level.
 * AHB-to-APB bridge, slot decoder, timer array and return mux.
 */

`timescale 1ns/1ps

`include "timer_config.svh"

module timer_subsystem
  import timer_pkg::*;
(
  input  logic                         hclk,
  input  logic                         reset,
  input  logic                         hsel,
  input  logic [31:0]                  haddr,
  input  logic [1:0]                   htrans,
  input  logic                         hwrite,
  input  logic [`TIMER_DATA_WIDTH-1:0] hwdata,
  input  logic                         hready_in,
  output logic [`TIMER_DATA_WIDTH-1:0] hrdata,
  output logic                         hreadyout,
  output hresp_e                       hresp,
  output logic                         timerint
);

  // Bridge to slots
  timer_addr_u                  paddr;
  logic                         psel;
  logic                         penable;
  logic                         pwrite;
  logic [`TIMER_DATA_WIDTH-1:0] pwdata;
  timer_reg_e                   pword;

  // Slots back to bridge
  logic [`TIMER_DATA_WIDTH-1:0] prdata;
  logic                         pready;
  logic                         pslverr;

  logic [`TIMER_COUNT-1:0]      slot_sel;
  logic                         decode_err;
  logic [`TIMER_DATA_WIDTH-1:0] slot_rdata [`TIMER_COUNT];
  logic [`TIMER_COUNT-1:0]      slot_ready;
  logic [`TIMER_COUNT-1:0]      slot_int;

  assign pword = timer_reg_e'(paddr.fields.word);

  ahb_apb_bridge u_bridge (
    .hclk      (hclk),
    .reset     (reset),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hwdata    (hwdata),
    .hready_in (hready_in),
    .hrdata    (hrdata),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  apb_slot_decoder u_decoder (
    .psel       (psel),
    .paddr      (paddr),
    .slot_sel   (slot_sel),
    .decode_err (decode_err)
  );

  // --------------------------------------------------------------------------
  // Timer array
  // --------------------------------------------------------------------------

  for (genvar i = 0; i < `TIMER_COUNT; i++) begin : g_timer
    apb_timer u_timer (
      .hclk     (hclk),
      .reset    (reset),
      .psel     (slot_sel[i]),
      .penable  (penable),
      .pwrite   (pwrite),
      .pword    (pword),
      .pwdata   (pwdata),
      .prdata   (slot_rdata[i]),
      .pready   (slot_ready[i]),
      .timerint (slot_int[i])
    );
  end

  apb_return_mux u_return_mux (
    .slot_sel   (slot_sel),
    .decode_err (decode_err),
    .slot_rdata (slot_rdata),
    .slot_ready (slot_ready),
    .slot_int   (slot_int),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .timerint   (timerint)
  );

endmodule

//--- verif/timer_subsystem_props.sv
/*
 * Concurrent assertions on the AHB-to-APB bridge.
 * APB setup/access order, data phase wait states, ERROR response shape.
 */

`timescale 1ns/1ps

module timer_subsystem_props
  import timer_pkg::*;
(
  input logic       hclk,
  input logic       reset,
  input logic       hsel,
  input logic [1:0] htrans,
  input logic       hready_in,
  input logic       hreadyout,
  input hresp_e     hresp,
  input logic       psel,
  input logic       penable
);

  logic accept;
  int   fail_count = 0;

  assign accept = hsel && hready_in && htrans[1] && hreadyout;

  // Access phase only after a setup cycle with psel alone
  a_setup_first: assert property (@(posedge hclk) disable iff (reset)
    $rose(penable) |-> $past(psel) && !$past(penable))
    else begin
      fail_count++;
      $error("penable rose without a setup cycle before it");
    end

  // Two wait states after each accepted transfer and none in between
  a_wait_states: assert property (@(posedge hclk) disable iff (reset)
    hreadyout == !($past(accept) || $past(accept, 2)))
    else begin
      fail_count++;
      $error("hreadyout low cycles do not match accepted transfers");
    end

  a_error_second: assert property (@(posedge hclk) disable iff (reset)
    (hresp == HRESP_ERROR && !hreadyout) |=> (hresp == HRESP_ERROR && hreadyout))
    else begin
      fail_count++;
      $error("ERROR response not held into a second cycle with hreadyout high");
    end

  a_error_first: assert property (@(posedge hclk) disable iff (reset)
    (hresp == HRESP_ERROR && hreadyout) |-> $past(hresp == HRESP_ERROR && !hreadyout))
    else begin
      fail_count++;
      $error("ERROR with hreadyout high not preceded by a wait cycle");
    end

endmodule

//--- verif/timer_subsystem_tb.sv
/*
 * Testbench for the timer subsystem.
 * Clock and reset, AHB driver tasks, value check, directed tests,
 * run timeout and final verdict.
 */

`timescale 1ns/1ps

`include "timer_config.svh"

module timer_subsystem_tb
  import timer_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 5000;

  logic        hclk;
  logic        reset;
  logic        hsel;
  logic [31:0] haddr;
  logic [1:0]  htrans;
  logic        hwrite;
  logic [31:0] hwdata;
  logic        hready_in;
  logic [31:0] hrdata;
  logic        hreadyout;
  hresp_e      hresp;
  logic        timerint;

  integer seed;
  int     errors = 0;
  int     checks = 0;
  int     cycle_count = 0;

  timer_subsystem dut0 (
    .hclk      (hclk),
    .reset     (reset),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hwdata    (hwdata),
    .hready_in (hready_in),
    .hrdata    (hrdata),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .timerint  (timerint)
  );

  bind ahb_apb_bridge timer_subsystem_props u_props (
    .hclk      (hclk),
    .reset     (reset),
    .hsel      (hsel),
    .htrans    (htrans),
    .hready_in (hready_in),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .psel      (psel),
    .penable   (penable)
  );

  always #50 hclk = ~hclk;

  // Run limit in clock cycles
  always @(posedge hclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: no verdict after %0d clock cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Check and bus driver tasks
  // --------------------------------------------------------------------------

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h",
               $time, name, actual, expected);
    end
  endtask

  // Byte address of one register from slot and word index
  function automatic logic [31:0] reg_addr(input logic [3:0] slot, input logic [5:0] word);
    return {20'd0, slot, word, 2'b00};
  endfunction

  task automatic run_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output hresp_e resp);
    int low_cycles;
    low_cycles = 0;
    resp = HRESP_OKAY;
    @(posedge hclk);
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= 2'b10;
    hwrite <= write;
    // Data phase starts at this address phase edge
    @(posedge hclk);
    hsel   <= 1'b0;
    htrans <= 2'b00;
    hwdata <= wdata;
    @(negedge hclk);
    while (!hreadyout && low_cycles < 8) begin
      if (hresp == HRESP_ERROR)
        resp = HRESP_ERROR;
      low_cycles++;
      @(negedge hclk);
    end
    if (!hreadyout) begin
      errors++;
      $display("Transfer to address 0x%08h did not complete", addr);
    end
    if (hresp == HRESP_ERROR)
      resp = HRESP_ERROR;
    check("hreadyout low cycles", 32'(low_cycles), 32'd2);
    rdata = hrdata;
  endtask

  task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data,
                           output hresp_e resp);
    logic [31:0] unused_rdata;
    run_transfer(1'b1, addr, data, unused_rdata, resp);
  endtask

  task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data,
                          output hresp_e resp);
    run_transfer(1'b0, addr, 32'd0, data, resp);
  endtask

  task automatic write_reg(input logic [3:0] slot, input logic [5:0] word,
                           input logic [31:0] data);
    hresp_e resp;
    ahb_write(reg_addr(slot, word), data, resp);
    check("hresp", 32'(resp), 32'(HRESP_OKAY));
  endtask

  task automatic read_reg(input logic [3:0] slot, input logic [5:0] word,
                          output logic [31:0] data);
    hresp_e resp;
    ahb_read(reg_addr(slot, word), data, resp);
    check("hresp", 32'(resp), 32'(HRESP_OKAY));
  endtask

  task automatic expect_reg(input string name, input logic [3:0] slot,
                            input logic [5:0] word, input logic [31:0] expected);
    logic [31:0] rd;
    read_reg(slot, word, rd);
    check(name, rd, expected);
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------

  task automatic verify_reset_state();
    check("hresp", 32'(hresp), 32'(HRESP_OKAY));
    check("hreadyout", 32'(hreadyout), 32'd1);
    check("timerint", 32'(timerint), 32'd0);
    for (int s = 0; s < `TIMER_COUNT; s++) begin
      for (int w = 0; w < 4; w++) begin
        expect_reg("register after reset", 4'(s), 6'(w), 32'd0);
      end
    end
  endtask

  task automatic write_read_back();
    logic [31:0] reload_val;
    logic [31:0] value_val;
    logic [31:0] ctrl_val;
    for (int s = 0; s < `TIMER_COUNT; s++) begin
      reload_val = $random(seed);
      value_val  = $random(seed);
      ctrl_val   = $random(seed);
      write_reg(4'(s), REG_RELOAD, reload_val);
      write_reg(4'(s), REG_VALUE, value_val);
      expect_reg("RELOAD", 4'(s), REG_RELOAD, reload_val);
      expect_reg("VALUE", 4'(s), REG_VALUE, value_val);
      // Only enable and interrupt enable are stored
      write_reg(4'(s), REG_CTRL, ctrl_val);
      expect_reg("CTRL", 4'(s), REG_CTRL, ctrl_val & 32'h3);
      write_reg(4'(s), REG_CTRL, 32'd0);
      write_reg(4'(s), REG_INTSTAT, 32'd1);
    end
  endtask

  task automatic countdown_reload();
    logic [31:0] v_val;
    logic [31:0] r_val;
    logic [31:0] rd;
    v_val = 32'd60 + ($random(seed) & 32'h1f);
    r_val = 32'd20 + ($random(seed) & 32'h0f);
    write_reg(4'd1, REG_VALUE, v_val);
    write_reg(4'd1, REG_RELOAD, r_val);
    write_reg(4'd1, REG_CTRL, 32'h1);
    read_reg(4'd1, REG_VALUE, rd);
    check("VALUE below start value", 32'(rd < v_val), 32'd1);
    repeat (v_val + 20) @(posedge hclk);
    expect_reg("INTSTAT after reload", 4'd1, REG_INTSTAT, 32'd1);
    check("timerint", 32'(timerint), 32'd0);
    read_reg(4'd1, REG_VALUE, rd);
    check("VALUE within RELOAD", 32'(rd <= r_val), 32'd1);
  endtask

  task automatic interrupt_flow();
    int waited;
    write_reg(4'd1, REG_CTRL, 32'h0);
    write_reg(4'd1, REG_VALUE, 32'd500);
    // Flag still set from the countdown test
    write_reg(4'd1, REG_CTRL, 32'h3);
    check("timerint", 32'(timerint), 32'd1);
    write_reg(4'd1, REG_INTSTAT, 32'h1);
    check("timerint", 32'(timerint), 32'd0);
    expect_reg("INTSTAT after clear", 4'd1, REG_INTSTAT, 32'd0);
    write_reg(4'd1, REG_VALUE, 32'd5);
    waited = 0;
    while (!timerint && waited < 40) begin
      @(negedge hclk);
      waited++;
    end
    check("timerint", 32'(timerint), 32'd1);
    for (int s = 0; s < `TIMER_COUNT; s++) begin
      if (s != 1)
        expect_reg("INTSTAT of other slot", 4'(s), REG_INTSTAT, 32'd0);
    end
    write_reg(4'd1, REG_CTRL, 32'h0);
    write_reg(4'd1, REG_INTSTAT, 32'h1);
    check("timerint", 32'(timerint), 32'd0);
  endtask

  task automatic unmapped_slot();
    logic [31:0] value_val;
    logic [31:0] reload_val;
    logic [31:0] rd;
    hresp_e      resp;
    value_val  = $random(seed);
    reload_val = $random(seed);
    write_reg(4'd0, REG_VALUE, value_val);
    write_reg(4'd0, REG_RELOAD, reload_val);
    ahb_write(reg_addr(4'd15, REG_VALUE), $random(seed), resp);
    check("hresp", 32'(resp), 32'(HRESP_ERROR));
    ahb_read(reg_addr(4'd15, REG_VALUE), rd, resp);
    check("hresp", 32'(resp), 32'(HRESP_ERROR));
    check("hrdata", rd, 32'd0);
    expect_reg("slot 0 VALUE", 4'd0, REG_VALUE, value_val);
    expect_reg("slot 0 RELOAD", 4'd0, REG_RELOAD, reload_val);
  endtask

  task automatic idle_transfers();
    logic [31:0] value_val;
    logic [31:0] reload_val;
    value_val  = $random(seed);
    reload_val = $random(seed);
    write_reg(4'd0, REG_VALUE, value_val);
    write_reg(4'd0, REG_RELOAD, reload_val);
    @(posedge hclk);
    hsel   <= 1'b1;
    hwrite <= 1'b1;
    htrans <= 2'b00;
    haddr  <= reg_addr(4'd0, REG_VALUE);
    for (int i = 0; i < 8; i++) begin
      hwdata <= $random(seed);
      @(negedge hclk);
      check("hresp", 32'(hresp), 32'(HRESP_OKAY));
      check("hreadyout", 32'(hreadyout), 32'd1);
      @(posedge hclk);
    end
    hsel <= 1'b0;
    expect_reg("slot 0 VALUE", 4'd0, REG_VALUE, value_val);
    expect_reg("slot 0 RELOAD", 4'd0, REG_RELOAD, reload_val);
    expect_reg("slot 0 CTRL", 4'd0, REG_CTRL, 32'd0);
  endtask

  initial begin
    seed      = 32'h5486;
    hclk      = 1'b0;
    reset     = 1'b1;
    hsel      = 1'b0;
    haddr     = 32'd0;
    htrans    = 2'b00;
    hwrite    = 1'b0;
    hwdata    = 32'd0;
    hready_in = 1'b1;
    repeat (10) @(posedge hclk);
    reset <= 1'b0;
    @(negedge hclk);
    verify_reset_state();
    write_read_back();
    countdown_reload();
    interrupt_flow();
    unmapped_slot();
    idle_transfers();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, dut0.u_bridge.u_props.fail_count);
    if (errors == 0 && dut0.u_bridge.u_props.fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+src
src/timer_pkg.sv
src/ahb_apb_bridge.sv
src/apb_slot_decoder.sv
src/apb_timer.sv
src/apb_return_mux.sv
src/timer_subsystem.sv
verif/timer_subsystem_props.sv
verif/timer_subsystem_tb.sv

//--- Makefile
# Verilator build and run of the timer subsystem testbench

VERILATOR ?= verilator
TOP       ?= timer_subsystem_tb
RTL_TOP   ?= timer_subsystem
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall
FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Verdict comes from the log, not from the simulator exit status
run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG) || ! grep -qF "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
